/* logic/or1k_decode_pkg.sv */
// OR1K decode definitions
package or1k_decode_pkg;

   localparam int INSN_W    = 32;
   localparam int OPCODE_W  = 6;
   localparam int ALU_OPC_W = 4;
   localparam int RF_ADDR_W = 5;
   localparam int IMM16_W   = 16;
   localparam int OPERAND_W = 32;
   localparam int LSU_LEN_W = 2;
   localparam int FLAGS_W   = 12;

   // Major opcodes in use
   localparam logic [OPCODE_W-1:0] OPCODE_J           = 6'h00;
   localparam logic [OPCODE_W-1:0] OPCODE_JAL         = 6'h01;
   localparam logic [OPCODE_W-1:0] OPCODE_BNF         = 6'h03;
   localparam logic [OPCODE_W-1:0] OPCODE_BF          = 6'h04;
   localparam logic [OPCODE_W-1:0] OPCODE_NOP         = 6'h05;
   localparam logic [OPCODE_W-1:0] OPCODE_MOVHI       = 6'h06;
   localparam logic [OPCODE_W-1:0] OPCODE_SYSTRAPSYNC = 6'h08;
   localparam logic [OPCODE_W-1:0] OPCODE_RFE         = 6'h09;
   localparam logic [OPCODE_W-1:0] OPCODE_JR          = 6'h11;
   localparam logic [OPCODE_W-1:0] OPCODE_JALR        = 6'h12;
   localparam logic [OPCODE_W-1:0] OPCODE_LWA         = 6'h1b;
   localparam logic [OPCODE_W-1:0] OPCODE_LWZ         = 6'h21;
   localparam logic [OPCODE_W-1:0] OPCODE_LWS         = 6'h22;
   localparam logic [OPCODE_W-1:0] OPCODE_LBZ         = 6'h23;
   localparam logic [OPCODE_W-1:0] OPCODE_LBS         = 6'h24;
   localparam logic [OPCODE_W-1:0] OPCODE_LHZ         = 6'h25;
   localparam logic [OPCODE_W-1:0] OPCODE_LHS         = 6'h26;
   localparam logic [OPCODE_W-1:0] OPCODE_ADDI        = 6'h27;
   localparam logic [OPCODE_W-1:0] OPCODE_ADDIC       = 6'h28;
   localparam logic [OPCODE_W-1:0] OPCODE_ANDI        = 6'h29;
   localparam logic [OPCODE_W-1:0] OPCODE_ORI         = 6'h2a;
   localparam logic [OPCODE_W-1:0] OPCODE_XORI        = 6'h2b;
   localparam logic [OPCODE_W-1:0] OPCODE_MULI        = 6'h2c;
   localparam logic [OPCODE_W-1:0] OPCODE_MFSPR       = 6'h2d;
   localparam logic [OPCODE_W-1:0] OPCODE_SHRTI       = 6'h2e;
   localparam logic [OPCODE_W-1:0] OPCODE_SFIMM       = 6'h2f;
   localparam logic [OPCODE_W-1:0] OPCODE_MTSPR       = 6'h30;
   localparam logic [OPCODE_W-1:0] OPCODE_SWA         = 6'h33;
   localparam logic [OPCODE_W-1:0] OPCODE_SW          = 6'h35;
   localparam logic [OPCODE_W-1:0] OPCODE_SB          = 6'h36;
   localparam logic [OPCODE_W-1:0] OPCODE_SH          = 6'h37;
   localparam logic [OPCODE_W-1:0] OPCODE_ALU         = 6'h38;
   localparam logic [OPCODE_W-1:0] OPCODE_SF          = 6'h39;

   // ALU functions, low nibble of register-form insns
   localparam logic [ALU_OPC_W-1:0] ALU_OPC_ADD   = 4'h0;
   localparam logic [ALU_OPC_W-1:0] ALU_OPC_ADDC  = 4'h1;
   localparam logic [ALU_OPC_W-1:0] ALU_OPC_SUB   = 4'h2;
   localparam logic [ALU_OPC_W-1:0] ALU_OPC_AND   = 4'h3;
   localparam logic [ALU_OPC_W-1:0] ALU_OPC_OR    = 4'h4;
   localparam logic [ALU_OPC_W-1:0] ALU_OPC_XOR   = 4'h5;
   localparam logic [ALU_OPC_W-1:0] ALU_OPC_MUL   = 4'h6;
   localparam logic [ALU_OPC_W-1:0] ALU_OPC_SHRT  = 4'h8;
   localparam logic [ALU_OPC_W-1:0] ALU_OPC_DIV   = 4'h9;
   localparam logic [ALU_OPC_W-1:0] ALU_OPC_DIVU  = 4'ha;
   localparam logic [ALU_OPC_W-1:0] ALU_OPC_MULU  = 4'hb;
   localparam logic [ALU_OPC_W-1:0] ALU_OPC_EXTBH = 4'hc;
   localparam logic [ALU_OPC_W-1:0] ALU_OPC_EXTW  = 4'hd;
   localparam logic [ALU_OPC_W-1:0] ALU_OPC_CMOV  = 4'he;
   localparam logic [ALU_OPC_W-1:0] ALU_OPC_FFL1  = 4'hf;

   localparam logic [1:0] SHRT_SLL = 2'd0;
   localparam logic [1:0] SHRT_SRL = 2'd1;
   localparam logic [1:0] SHRT_SRA = 2'd2;
   localparam logic [1:0] SHRT_ROR = 2'd3;

   // System group selector sits in the rd position
   localparam logic [4:0] SYS_SYSCALL = 5'b00000;
   localparam logic [4:0] SYS_TRAP    = 5'b01000;
   localparam logic [4:0] SYS_MSYNC   = 5'b10000;

   localparam logic [RF_ADDR_W-1:0] LINK_REG = 5'd9;

   localparam logic [LSU_LEN_W-1:0] LSU_LEN_BYTE = 2'b00;
   localparam logic [LSU_LEN_W-1:0] LSU_LEN_HALF = 2'b01;
   localparam logic [LSU_LEN_W-1:0] LSU_LEN_WORD = 2'b10;

   // Class flag bit positions
   localparam int FLAG_LOAD    = 0;
   localparam int FLAG_STORE   = 1;
   localparam int FLAG_ATOMIC  = 2;
   localparam int FLAG_BRANCH  = 3;
   localparam int FLAG_JAL     = 4;
   localparam int FLAG_ALU     = 5;
   localparam int FLAG_SETFLAG = 6;
   localparam int FLAG_MUL     = 7;
   localparam int FLAG_MOVHI   = 8;
   localparam int FLAG_MFSPR   = 9;
   localparam int FLAG_MTSPR   = 10;
   localparam int FLAG_RFE     = 11;

   // Flags, ALU opc, 3 regs, imm16, operand, sel, len, zext, wb, 3 exceptions
   localparam int REC_W = FLAGS_W + ALU_OPC_W + 3 * RF_ADDR_W + IMM16_W + OPERAND_W
                          + 1 + LSU_LEN_W + 2 + 3;

   localparam int QUEUE_DEPTH = 4;
   localparam int DS_CREDITS  = 2;
   localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
   localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);
   localparam int DS_CRED_W   = $clog2(DS_CREDITS + 1);

   // Fixed core configuration
   localparam logic CFG_ATOMIC = 1'b1;
   localparam logic CFG_MUL    = 1'b1;
   localparam logic CFG_SRA    = 1'b1;
   localparam logic CFG_DIV    = 1'b0;
   localparam logic CFG_ADDC   = 1'b0;
   localparam logic CFG_ROR    = 1'b0;
   localparam logic CFG_EXT    = 1'b0;
   localparam logic CFG_CMOV   = 1'b0;
   localparam logic CFG_FFL1   = 1'b0;

   typedef union packed {
      struct packed {
         logic [OPCODE_W-1:0]  opcode;
         logic [RF_ADDR_W-1:0] rd;
         logic [RF_ADDR_W-1:0] ra;
         logic [RF_ADDR_W-1:0] rb;
         logic [2:0]           rsvd_hi;
         logic [1:0]           shrt;
         logic [1:0]           rsvd_lo;
         logic [ALU_OPC_W-1:0] alu_opc;
      } r;
      struct packed {
         logic [OPCODE_W-1:0]  opcode;
         logic [4:0]           imm_hi;
         logic [RF_ADDR_W-1:0] ra;
         logic [RF_ADDR_W-1:0] rb;
         logic [10:0]          imm_lo;
      } s;
   } insn_word_u;

endpackage

/* logic/or1k_operand_decode.sv */
// OR1K operand decoder
`timescale 1ns/1ps

module or1k_operand_decode
   import or1k_decode_pkg::*;
(
   input  insn_word_u           insn_i,
   output logic [RF_ADDR_W-1:0] rfd_adr_o,
   output logic [RF_ADDR_W-1:0] rfa_adr_o,
   output logic [RF_ADDR_W-1:0] rfb_adr_o,
   output logic [IMM16_W-1:0]   imm16_o,
   output logic [OPERAND_W-1:0] immediate_o,
   output logic                 immediate_sel_o
);

   logic [OPCODE_W-1:0] opc;
   logic                link;
   logic                split_imm;
   logic                sext_sel;
   logic                zext_sel;
   logic                high_sel;

   assign opc = insn_i.r.opcode;

   // jal and jalr write the return address to r9
   assign link      = (opc == OPCODE_JAL) || (opc == OPCODE_JALR);
   assign rfd_adr_o = link ? LINK_REG : insn_i.r.rd;
   assign rfa_adr_o = insn_i.r.ra;
   assign rfb_adr_o = insn_i.r.rb;

   // Stores and mtspr carry rb in bits 15:11, so the immediate is split
   assign split_imm = (opc == OPCODE_SW) || (opc == OPCODE_SB) || (opc == OPCODE_SH) ||
                      ((opc == OPCODE_SWA) && CFG_ATOMIC) || (opc == OPCODE_MTSPR);
   assign imm16_o   = split_imm ? {insn_i.s.imm_hi, insn_i.s.imm_lo}
                                : {insn_i.s.rb, insn_i.s.imm_lo};

   assign sext_sel = ((opc[5:4] == 2'b10) && (opc != OPCODE_ORI) && (opc != OPCODE_ANDI)) ||
                     (opc == OPCODE_SWA) || (opc == OPCODE_LWA) ||
                     (opc == OPCODE_SW) || (opc == OPCODE_SH) || (opc == OPCODE_SB);
   // Logical immediates and SPR numbers are unsigned
   assign zext_sel = (opc == OPCODE_ORI) || (opc == OPCODE_ANDI) || (opc == OPCODE_MTSPR);
   assign high_sel = (opc == OPCODE_MOVHI);

   always_comb begin
      if (sext_sel) begin
         immediate_o = {{(OPERAND_W - IMM16_W){imm16_o[IMM16_W-1]}}, imm16_o};
      end else if (zext_sel) begin
         immediate_o = {{(OPERAND_W - IMM16_W){1'b0}}, imm16_o};
      end else begin
         immediate_o = {imm16_o, {(OPERAND_W - IMM16_W){1'b0}}};
      end
   end

   assign immediate_sel_o = sext_sel || zext_sel || high_sel;

endmodule

/* logic/or1k_class_decode.sv */
// OR1K operation class decoder
`timescale 1ns/1ps

module or1k_class_decode
   import or1k_decode_pkg::*;
(
   input  insn_word_u           insn_i,
   output logic [FLAGS_W-1:0]   flags_o,
   output logic [ALU_OPC_W-1:0] alu_opc_o,
   output logic [LSU_LEN_W-1:0] lsu_len_o,
   output logic                 lsu_zext_o,
   output logic                 rf_wb_o
);

   logic [OPCODE_W-1:0]  opc;
   logic [ALU_OPC_W-1:0] fn;
   logic                 is_alu;
   logic                 store;
   logic                 jal;

   assign opc    = insn_i.r.opcode;
   assign fn     = insn_i.r.alu_opc;
   assign is_alu = (opc == OPCODE_ALU);
   assign jal    = (opc == OPCODE_JAL) || (opc == OPCODE_JALR);
   assign store  = (opc == OPCODE_SW) || (opc == OPCODE_SB) || (opc == OPCODE_SH) ||
                   ((opc == OPCODE_SWA) && CFG_ATOMIC);

   // Loads occupy 10_0000 to 10_0110, plus lwa
   assign flags_o[FLAG_LOAD]    = ((opc[5:3] == 3'b100) && !(&opc[2:0])) ||
                                  ((opc == OPCODE_LWA) && CFG_ATOMIC);
   assign flags_o[FLAG_STORE]   = store;
   assign flags_o[FLAG_ATOMIC]  = ((opc == OPCODE_LWA) || (opc == OPCODE_SWA)) && CFG_ATOMIC;
   // Lowest opcodes are immediate jumps and branches
   assign flags_o[FLAG_BRANCH]  = (opc < OPCODE_NOP) || (opc == OPCODE_JR) || jal;
   assign flags_o[FLAG_JAL]     = jal;
   assign flags_o[FLAG_ALU]     = is_alu || (opc == OPCODE_ORI) || (opc == OPCODE_ANDI) ||
                                  (opc == OPCODE_XORI);
   assign flags_o[FLAG_SETFLAG] = (opc == OPCODE_SF) || (opc == OPCODE_SFIMM);
   assign flags_o[FLAG_MUL]     = (is_alu && ((fn == ALU_OPC_MUL) || (fn == ALU_OPC_MULU))) ||
                                  (opc == OPCODE_MULI);
   assign flags_o[FLAG_MOVHI]   = (opc == OPCODE_MOVHI);
   assign flags_o[FLAG_MFSPR]   = (opc == OPCODE_MFSPR);
   assign flags_o[FLAG_MTSPR]   = (opc == OPCODE_MTSPR);
   assign flags_o[FLAG_RFE]     = (opc == OPCODE_RFE);

   // Immediate logic ops reuse the register-form ALU function
   always_comb begin
      case (opc)
         OPCODE_ORI:  alu_opc_o = ALU_OPC_OR;
         OPCODE_ANDI: alu_opc_o = ALU_OPC_AND;
         OPCODE_XORI: alu_opc_o = ALU_OPC_XOR;
         default:     alu_opc_o = fn;
      endcase
   end

   always_comb begin
      case (opc)
         OPCODE_SB, OPCODE_LBZ, OPCODE_LBS: lsu_len_o = LSU_LEN_BYTE;
         OPCODE_SH, OPCODE_LHZ, OPCODE_LHS: lsu_len_o = LSU_LEN_HALF;
         default:                           lsu_len_o = LSU_LEN_WORD;
      endcase
   end

   // Odd load opcodes are the zero-extending ones
   assign lsu_zext_o = opc[0];

   assign rf_wb_o = jal || (opc == OPCODE_MOVHI) || (opc == OPCODE_LWA) ||
                    ((opc[5:4] == 2'b10) && (opc != OPCODE_SFIMM)) ||
                    ((opc[5:4] == 2'b11) && (opc != OPCODE_SF) && (opc != OPCODE_MTSPR) &&
                     !store);

endmodule

/* logic/or1k_illegal_decode.sv */
// OR1K exception decoder
`timescale 1ns/1ps

module or1k_illegal_decode
   import or1k_decode_pkg::*;
(
   input  insn_word_u insn_i,
   output logic       except_illegal_o,
   output logic       except_syscall_o,
   output logic       except_trap_o
);

   logic [OPCODE_W-1:0] opc;
   logic [4:0]          sys_sel;
   logic                alu_illegal;

   // Shift variants shared by shrti and the register ALU form
   function automatic logic shrt_illegal(input logic [1:0] sel);
      logic ill;
      case (sel)
         SHRT_SLL, SHRT_SRL: ill = 1'b0;
         SHRT_SRA:           ill = !CFG_SRA;
         SHRT_ROR:           ill = !CFG_ROR;
         default:            ill = 1'b1;
      endcase
      return ill;
   endfunction

   assign opc     = insn_i.r.opcode;
   assign sys_sel = insn_i.r.rd;

   always_comb begin
      case (insn_i.r.alu_opc)
         ALU_OPC_ADD, ALU_OPC_SUB, ALU_OPC_OR, ALU_OPC_XOR, ALU_OPC_AND:
            alu_illegal = 1'b0;
         ALU_OPC_ADDC:               alu_illegal = !CFG_ADDC;
         ALU_OPC_MUL, ALU_OPC_MULU:  alu_illegal = !CFG_MUL;
         ALU_OPC_DIV, ALU_OPC_DIVU:  alu_illegal = !CFG_DIV;
         ALU_OPC_EXTBH, ALU_OPC_EXTW: alu_illegal = !CFG_EXT;
         ALU_OPC_CMOV:               alu_illegal = !CFG_CMOV;
         ALU_OPC_FFL1:               alu_illegal = !CFG_FFL1;
         ALU_OPC_SHRT:               alu_illegal = shrt_illegal(insn_i.r.shrt);
         default:                    alu_illegal = 1'b1;
      endcase
   end

   // FPU, custom, MAC and 64-bit opcodes fall to the default
   always_comb begin
      case (opc)
         OPCODE_J, OPCODE_JAL, OPCODE_BNF, OPCODE_BF, OPCODE_NOP, OPCODE_MOVHI,
         OPCODE_RFE, OPCODE_JR, OPCODE_JALR, OPCODE_LWZ, OPCODE_LWS, OPCODE_LBZ,
         OPCODE_LBS, OPCODE_LHZ, OPCODE_LHS, OPCODE_ADDI, OPCODE_ANDI, OPCODE_ORI,
         OPCODE_XORI, OPCODE_MFSPR, OPCODE_SFIMM, OPCODE_MTSPR, OPCODE_SW, OPCODE_SB,
         OPCODE_SH, OPCODE_SF:
            except_illegal_o = 1'b0;
         OPCODE_LWA, OPCODE_SWA:
            except_illegal_o = !CFG_ATOMIC;
         OPCODE_ADDIC:
            except_illegal_o = !CFG_ADDC;
         OPCODE_MULI:
            except_illegal_o = !CFG_MUL;
         OPCODE_SHRTI:
            except_illegal_o = shrt_illegal(insn_i.r.shrt);
         OPCODE_ALU:
            except_illegal_o = alu_illegal;
         OPCODE_SYSTRAPSYNC:
            except_illegal_o = !((sys_sel == SYS_SYSCALL) || (sys_sel == SYS_TRAP) ||
                                 (sys_sel == SYS_MSYNC));
         default:
            except_illegal_o = 1'b1;
      endcase
   end

   assign except_syscall_o = (opc == OPCODE_SYSTRAPSYNC) && (sys_sel == SYS_SYSCALL);
   assign except_trap_o    = (opc == OPCODE_SYSTRAPSYNC) && (sys_sel == SYS_TRAP);

endmodule

/* logic/or1k_decode_queue.sv */
// Decoded record queue
`timescale 1ns/1ps

module or1k_decode_queue
   import or1k_decode_pkg::*;
(
   input  logic             clk,
   input  logic             arst_n_i,
   input  logic             push_i,
   input  logic [REC_W-1:0] rec_i,
   input  logic             exec_credit_i,
   output logic [REC_W-1:0] rec_o,
   output logic             valid_o,
   output logic             fetch_credit_o
);

   logic [REC_W-1:0]     mem_q [QUEUE_DEPTH];
   logic [QPTR_W-1:0]    wr_ptr_q;
   logic [QPTR_W-1:0]    rd_ptr_q;
   logic [QCNT_W-1:0]    count_q;
   logic [DS_CRED_W-1:0] credits_q;
   logic                 pop;

   // Fetch never pushes without a credit, so no full check is needed
   always_ff @(posedge clk) begin
      if (push_i) begin
         mem_q[wr_ptr_q] <= rec_i;
      end
   end

   // Head leaves whenever execute has room for it
   assign pop            = (count_q != '0) && (credits_q != '0);
   assign valid_o        = pop;
   assign fetch_credit_o = pop;
   assign rec_o          = mem_q[rd_ptr_q];

   // Pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + QPTR_W'(1);
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + QPTR_W'(1);
         end
         count_q <= count_q + QCNT_W'(push_i) - QCNT_W'(pop);
      end
   end

   // Execute credits, one spent per transfer and one back per pulse
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         credits_q <= DS_CRED_W'(DS_CREDITS);
      end else begin
         credits_q <= credits_q - DS_CRED_W'(pop) + DS_CRED_W'(exec_credit_i);
      end
   end

endmodule

/* logic/or1k_decode_stage.sv */
// OR1K decode stage
`timescale 1ns/1ps

module or1k_decode_stage
   import or1k_decode_pkg::*;
(
   input  logic                 clk,
   input  logic                 arst_n_i,
   input  logic                 insn_valid_i,
   input  logic [INSN_W-1:0]    insn_i,
   input  logic                 exec_credit_i,
   output logic                 fetch_credit_o,
   output logic                 dec_valid_o,
   output logic [FLAGS_W-1:0]   dec_flags_o,
   output logic [ALU_OPC_W-1:0] dec_alu_opc_o,
   output logic [RF_ADDR_W-1:0] dec_rfd_adr_o,
   output logic [RF_ADDR_W-1:0] dec_rfa_adr_o,
   output logic [RF_ADDR_W-1:0] dec_rfb_adr_o,
   output logic [IMM16_W-1:0]   dec_imm16_o,
   output logic [OPERAND_W-1:0] dec_immediate_o,
   output logic                 dec_immediate_sel_o,
   output logic [LSU_LEN_W-1:0] dec_lsu_len_o,
   output logic                 dec_lsu_zext_o,
   output logic                 dec_rf_wb_o,
   output logic                 dec_except_illegal_o,
   output logic                 dec_except_syscall_o,
   output logic                 dec_except_trap_o
);

   insn_word_u           insn;
   logic [FLAGS_W-1:0]   flags;
   logic [ALU_OPC_W-1:0] alu_opc;
   logic [RF_ADDR_W-1:0] rfd_adr;
   logic [RF_ADDR_W-1:0] rfa_adr;
   logic [RF_ADDR_W-1:0] rfb_adr;
   logic [IMM16_W-1:0]   imm16;
   logic [OPERAND_W-1:0] immediate;
   logic                 immediate_sel;
   logic [LSU_LEN_W-1:0] lsu_len;
   logic                 lsu_zext;
   logic                 rf_wb;
   logic                 illegal;
   logic                 syscall;
   logic                 trap;
   logic [REC_W-1:0]     rec_in;
   logic [REC_W-1:0]     rec_out;

   assign insn = insn_i;

   or1k_operand_decode u_operand (
      .insn_i          (insn),
      .rfd_adr_o       (rfd_adr),
      .rfa_adr_o       (rfa_adr),
      .rfb_adr_o       (rfb_adr),
      .imm16_o         (imm16),
      .immediate_o     (immediate),
      .immediate_sel_o (immediate_sel)
   );

   or1k_class_decode u_class (
      .insn_i     (insn),
      .flags_o    (flags),
      .alu_opc_o  (alu_opc),
      .lsu_len_o  (lsu_len),
      .lsu_zext_o (lsu_zext),
      .rf_wb_o    (rf_wb)
   );

   or1k_illegal_decode u_illegal (
      .insn_i           (insn),
      .except_illegal_o (illegal),
      .except_syscall_o (syscall),
      .except_trap_o    (trap)
   );

   // Record layout, flags in the top bits
   assign rec_in = {flags, alu_opc, rfd_adr, rfa_adr, rfb_adr, imm16, immediate,
                    immediate_sel, lsu_len, lsu_zext, rf_wb, illegal, syscall, trap};

   or1k_decode_queue u_queue (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .push_i         (insn_valid_i),
      .rec_i          (rec_in),
      .exec_credit_i  (exec_credit_i),
      .rec_o          (rec_out),
      .valid_o        (dec_valid_o),
      .fetch_credit_o (fetch_credit_o)
   );

   assign {dec_flags_o, dec_alu_opc_o, dec_rfd_adr_o, dec_rfa_adr_o, dec_rfb_adr_o,
           dec_imm16_o, dec_immediate_o, dec_immediate_sel_o, dec_lsu_len_o,
           dec_lsu_zext_o, dec_rf_wb_o, dec_except_illegal_o, dec_except_syscall_o,
           dec_except_trap_o} = rec_out;

endmodule

/* tests/tb_or1k_decode_stage.sv */
// OR1K decode stage testbench
`timescale 1ns/1ps

module tb_or1k_decode_stage
   import or1k_decode_pkg::*;
();

   localparam int NUM_INSN = 200;
   localparam int CLS_W    = FLAGS_W + ALU_OPC_W + LSU_LEN_W + 2;
   localparam int REG_W    = 3 * RF_ADDR_W;
   localparam int IMM_W    = IMM16_W + OPERAND_W + 1;

   typedef struct packed {
      logic [CLS_W-1:0] cls;
      logic [REG_W-1:0] regs;
      logic [IMM_W-1:0] imms;
      logic [2:0]       excs;
   } exp_t;

   logic                 clk = 1'b0;
   logic                 arst_n_i;
   logic                 insn_valid_i = 1'b0;
   logic [INSN_W-1:0]    insn_i = '0;
   logic                 exec_credit_i = 1'b0;
   logic                 fetch_credit_o;
   logic                 dec_valid_o;
   logic [FLAGS_W-1:0]   dec_flags_o;
   logic [ALU_OPC_W-1:0] dec_alu_opc_o;
   logic [RF_ADDR_W-1:0] dec_rfd_adr_o;
   logic [RF_ADDR_W-1:0] dec_rfa_adr_o;
   logic [RF_ADDR_W-1:0] dec_rfb_adr_o;
   logic [IMM16_W-1:0]   dec_imm16_o;
   logic [OPERAND_W-1:0] dec_immediate_o;
   logic                 dec_immediate_sel_o;
   logic [LSU_LEN_W-1:0] dec_lsu_len_o;
   logic                 dec_lsu_zext_o;
   logic                 dec_rf_wb_o;
   logic                 dec_except_illegal_o;
   logic                 dec_except_syscall_o;
   logic                 dec_except_trap_o;

   logic [15:0] lfsr_q = 16'd36248;
   exp_t        exp_q[$];
   int          exec_ret_cnt = 0;
   int          sent_cnt = 0;
   int          recv_cnt = 0;
   int          fcred_cnt = 0;
   bit          feeding = 1'b0;
   bit          exec_en = 1'b0;

   // Directed words for div, addc, ror, syscall, trap and a custom opcode
   logic [INSN_W-1:0] directed [6] = '{32'hE0000009, 32'hE0000001, 32'hE00000C8,
                                       32'h20000000, 32'h21000000, 32'h70000000};
   logic [OPCODE_W-1:0] opc_tab [16] = '{6'h01, 6'h03, 6'h06, 6'h08, 6'h09, 6'h12,
                                         6'h1b, 6'h23, 6'h26, 6'h28, 6'h29, 6'h2a,
                                         6'h2e, 6'h30, 6'h33, 6'h38};

   or1k_decode_stage uut (.*);

   always #50 clk = ~clk;

   // Fibonacci LFSR with taps at bits 16, 14, 13 and 11
   function logic lfsr_step();
      logic fb;
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      return fb;
   endfunction

   function logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_step()};
      end
      return v;
   endfunction

   function logic [INSN_W-1:0] gen_insn(input int idx);
      logic [INSN_W-1:0] w;
      if (idx < 6) begin
         return directed[idx];
      end
      w[25:0] = 26'(rand_bits(26));
      // Half from the table and half any opcode at all
      if (rand_bits(1)) begin
         w[31:26] = opc_tab[4'(rand_bits(4))];
      end else begin
         w[31:26] = 6'(rand_bits(6));
      end
      if (w[31:26] == OPCODE_SYSTRAPSYNC) begin
         w[25:21] = 5'(rand_bits(2) << 3);
      end
      return w;
   endfunction

   // Credits fetch still holds toward the stage
   function int fetch_credits_held();
      return QUEUE_DEPTH + fcred_cnt - sent_cnt;
   endfunction

   function automatic logic shift_bad(input logic [1:0] s);
      return (s == SHRT_ROR);
   endfunction

   // Expected record built from the ISA decode rules
   function automatic exp_t ref_decode(input logic [INSN_W-1:0] w);
      logic [5:0]  op;
      logic [3:0]  fn;
      logic        st;
      logic        sx;
      logic        zx;
      logic [15:0] i16;
      logic [31:0] imm;
      logic [11:0] fl;
      logic [3:0]  alu;
      logic [1:0]  len;
      logic        wb;
      logic        ill;
      exp_t        e;
      op  = w[31:26];
      fn  = w[3:0];
      st  = (op == 6'h33) || (op == 6'h35) || (op == 6'h36) || (op == 6'h37);
      i16 = (st || op == 6'h30) ? {w[25:21], w[10:0]} : w[15:0];
      sx  = (op >= 6'h20 && op <= 6'h2f && op != 6'h29 && op != 6'h2a) || st || op == 6'h1b;
      zx  = (op == 6'h29) || (op == 6'h2a) || (op == 6'h30);
      if (sx) imm = {{16{i16[15]}}, i16};
      else if (zx) imm = {16'h0, i16};
      else imm = {i16, 16'h0};
      fl = '0;
      fl[FLAG_LOAD]    = (op >= 6'h20 && op <= 6'h26) || op == 6'h1b;
      fl[FLAG_STORE]   = st;
      fl[FLAG_ATOMIC]  = (op == 6'h1b) || (op == 6'h33);
      fl[FLAG_BRANCH]  = (op <= 6'h04) || op == 6'h11 || op == 6'h12;
      fl[FLAG_JAL]     = (op == 6'h01) || (op == 6'h12);
      fl[FLAG_ALU]     = (op == 6'h38) || (op == 6'h29) || (op == 6'h2a) || (op == 6'h2b);
      fl[FLAG_SETFLAG] = (op == 6'h39) || (op == 6'h2f);
      fl[FLAG_MUL]     = (op == 6'h2c) || (op == 6'h38 && (fn == 4'h6 || fn == 4'hb));
      fl[FLAG_MOVHI]   = (op == 6'h06);
      fl[FLAG_MFSPR]   = (op == 6'h2d);
      fl[FLAG_MTSPR]   = (op == 6'h30);
      fl[FLAG_RFE]     = (op == 6'h09);
      case (op)
         6'h2a:   alu = 4'h4;
         6'h29:   alu = 4'h3;
         6'h2b:   alu = 4'h5;
         default: alu = fn;
      endcase
      case (op)
         6'h36, 6'h23, 6'h24: len = 2'b00;
         6'h37, 6'h25, 6'h26: len = 2'b01;
         default:             len = 2'b10;
      endcase
      wb = fl[FLAG_JAL] || op == 6'h06 || op == 6'h1b ||
           (op >= 6'h20 && op <= 6'h2e) || (op >= 6'h30 && op != 6'h39 && op != 6'h30 && !st);
      case (op)
         6'h08:   ill = !(w[25:21] == 5'd0 || w[25:21] == 5'd8 || w[25:21] == 5'd16);
         6'h28:   ill = 1'b1;
         6'h2e:   ill = shift_bad(w[7:6]);
         6'h38:   ill = (fn == 4'h8) ? shift_bad(w[7:6]) :
                        !(fn inside {4'h0, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'hb});
         default: ill = !(op inside {6'h00, 6'h01, 6'h03, 6'h04, 6'h05, 6'h06, 6'h09,
                                     6'h11, 6'h12, 6'h1b, [6'h21:6'h27], [6'h29:6'h2d],
                                     6'h2f, 6'h30, 6'h33, [6'h35:6'h37], 6'h39});
      endcase
      e.cls  = {fl, alu, len, op[0], wb};
      e.regs = {(fl[FLAG_JAL] ? 5'd9 : w[25:21]), w[20:16], w[15:11]};
      e.imms = {i16, imm, sx || zx || op == 6'h06};
      e.excs = {ill, op == 6'h08 && w[25:21] == 5'd0, op == 6'h08 && w[25:21] == 5'd8};
      return e;
   endfunction

   task fail_run(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   task check_class(input string name, input logic [CLS_W-1:0] exp, input logic [CLS_W-1:0] act);
      if (exp !== act) fail_run($sformatf("ERR %s class exp=%h act=%h", name, exp, act));
   endtask

   task check_regs(input string name, input logic [REG_W-1:0] exp, input logic [REG_W-1:0] act);
      if (exp !== act) fail_run($sformatf("ERR %s regs exp=%h act=%h", name, exp, act));
   endtask

   task check_imms(input string name, input logic [IMM_W-1:0] exp, input logic [IMM_W-1:0] act);
      if (exp !== act) fail_run($sformatf("ERR %s imms exp=%h act=%h", name, exp, act));
   endtask

   task check_excs(input string name, input logic [2:0] exp, input logic [2:0] act);
      if (exp !== act) fail_run($sformatf("ERR %s excs exp=%b act=%b", name, exp, act));
   endtask

   // Fetch and execute models share one edge so the LFSR order is fixed
   always @(negedge clk) begin
      logic [INSN_W-1:0] w;
      insn_valid_i  <= 1'b0;
      exec_credit_i <= 1'b0;
      if (feeding && sent_cnt < NUM_INSN && fetch_credits_held() > 0) begin
         w = gen_insn(sent_cnt);
         insn_i       <= w;
         insn_valid_i <= 1'b1;
         exp_q.push_back(ref_decode(w));
         sent_cnt++;
      end
      if (exec_en && recv_cnt > exec_ret_cnt && rand_bits(1)) begin
         exec_credit_i <= 1'b1;
         exec_ret_cnt++;
      end
   end

   // Comparing process
   always @(posedge clk) begin
      exp_t  e;
      string tn;
      if (arst_n_i && fetch_credit_o) begin
         fcred_cnt++;
      end
      if (arst_n_i && dec_valid_o) begin
         if (exp_q.size() == 0) fail_run("Record received with nothing outstanding");
         e  = exp_q.pop_front();
         tn = $sformatf("rec%0d", recv_cnt);
         check_class(tn, e.cls, {dec_flags_o, dec_alu_opc_o, dec_lsu_len_o,
                                 dec_lsu_zext_o, dec_rf_wb_o});
         check_regs(tn, e.regs, {dec_rfd_adr_o, dec_rfa_adr_o, dec_rfb_adr_o});
         check_imms(tn, e.imms, {dec_imm16_o, dec_immediate_o, dec_immediate_sel_o});
         check_excs(tn, e.excs, {dec_except_illegal_o, dec_except_syscall_o,
                                 dec_except_trap_o});
         recv_cnt++;
      end
   end

   initial begin
      int i;
      arst_n_i = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      arst_n_i = 1'b1;
      repeat (4) begin
         @(posedge clk);
         if (dec_valid_o || fetch_credit_o) fail_run("Output active before any instruction");
      end
      feeding = 1'b1;
      // Stall phase with no execute credits returned
      i = 0;
      while (i < 40 && !(recv_cnt == DS_CREDITS && fetch_credits_held() == 0)) begin
         @(posedge clk);
         i++;
      end
      if (fetch_credits_held() != 0) fail_run("Timeout waiting for fetch to run out of credits");
      repeat (8) @(posedge clk);
      if (recv_cnt != DS_CREDITS) fail_run("Records passed without execute credits");
      if (sent_cnt - recv_cnt != QUEUE_DEPTH) fail_run("Queue held wrong outstanding count");
      exec_en = 1'b1;
      for (i = 0; i < 5000 && recv_cnt < NUM_INSN; i++) @(posedge clk);
      if (recv_cnt < NUM_INSN) fail_run("Timeout waiting for all records");
      repeat (4) @(posedge clk);
      if (fcred_cnt != recv_cnt) begin
         fail_run("Fetch credit pulses differ from records");
      end else begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule

/* or1k_decode_stage.f */
logic/or1k_decode_pkg.sv
logic/or1k_operand_decode.sv
logic/or1k_class_decode.sv
logic/or1k_illegal_decode.sv
logic/or1k_decode_queue.sv
logic/or1k_decode_stage.sv
tests/tb_or1k_decode_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_or1k_decode_stage
FLIST     ?= or1k_decode_stage.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wall

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
